// ==== i2c_pkg.sv ====
// Shared widths, vector types and state encodings for the I2C master
package i2c_pkg;

  localparam int timer_w = 10;  // SCL period counters, up to 1023 clocks
  localparam int byte_w  = 8;

  typedef logic [byte_w-1:0]  byte_t;        // One data byte
  typedef logic [byte_w-1:0]  addr_frame_t;  // 7-bit address, R/W in bit 0 (1 = read)
  typedef logic [timer_w-1:0] tick_t;        // Counter values and timing parameters
  typedef logic [3:0]         bit_idx_t;     // Bit position within a frame, 0 to 8

  // SCL period the sequencer asks the timer to run
  typedef enum logic [1:0] {
    phase_idle,
    phase_hold_start,
    phase_low,
    phase_high
  } scl_phase_t;

  // Transaction states, each bit state spans both SCL halves
  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_addr,
    st_addr_ack,
    st_data,
    st_data_ack,
    st_stop_low,
    st_stop_high
  } xfer_state_t;

endpackage

// ==== bit_clock_if.sv ====
// Interface carrying the SCL phase request and the timer strobes
`timescale 1ns/1ps

interface bit_clock_if;

  i2c_pkg::scl_phase_t phase;  // Period requested by the sequencer
  logic scl_low;               // Pull SCL low
  logic change_strobe;         // SDA may change, tsu_dat before SCL rises
  logic sample_strobe;         // Sample SDA in the high half
  logic stop_strobe;           // STOP setup time met
  logic phase_done;            // Last cycle of the current period

  modport timer (
    input  phase,
    output scl_low, change_strobe, sample_strobe, stop_strobe, phase_done
  );

  modport sequencer (
    output phase,
    input  scl_low, change_strobe, sample_strobe, stop_strobe, phase_done
  );

endinterface

// ==== frame_data_if.sv ====
// Interface between the transfer sequencer and the frame shift registers
`timescale 1ns/1ps

interface frame_data_if;

  logic load;        // Capture address and data, clear receive register
  logic addr_shift;  // Advance the address frame by one bit
  logic tx_shift;    // Advance the transmit data by one bit
  logic rx_shift;    // Shift rx_bit into the receive register
  logic rx_bit;      // Sampled SDA level
  logic addr_bit;    // Current address bit, MSB first
  logic tx_bit;      // Current transmit bit, MSB first
  logic read_mode;   // Captured R/W bit

  modport sequencer (
    output load, addr_shift, tx_shift, rx_shift, rx_bit,
    input  addr_bit, tx_bit, read_mode
  );

  modport shifter (
    input  load, addr_shift, tx_shift, rx_shift, rx_bit,
    output addr_bit, tx_bit, read_mode
  );

endinterface

// ==== scl_timer.sv ====
// SCL period counter that decodes the bus timing strobes for each phase
`timescale 1ns/1ps

module scl_timer #(
  parameter i2c_pkg::tick_t thd_sta      = 12,  // START hold
  parameter i2c_pkg::tick_t tlow         = 16,  // SCL low period
  parameter i2c_pkg::tick_t thigh        = 14,  // SCL high period
  parameter i2c_pkg::tick_t tsu_dat      = 6,   // Data setup before SCL rises
  parameter i2c_pkg::tick_t tsu_sto      = 10,  // STOP setup after SCL rises
  parameter i2c_pkg::tick_t thigh_sample = 5    // SDA sample point in the high half
) (
  input  logic        clk,
  input  logic        rst,
  bit_clock_if.timer  bc
);

  i2c_pkg::tick_t      cnt;         // Registered tick count
  i2c_pkg::tick_t      count;       // Count seen this cycle, zero on a new phase
  i2c_pkg::tick_t      period;      // Length of the running phase
  i2c_pkg::scl_phase_t last_phase;  // Phase of the previous cycle
  logic                restart;

  assign restart = (bc.phase != last_phase);  // Sequencer moved on
  assign count   = restart ? '0 : cnt;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt        <= '0;
      last_phase <= i2c_pkg::phase_idle;
    end else begin
      last_phase <= bc.phase;
      if (bc.phase == i2c_pkg::phase_idle)
        cnt <= '0;  // Hold while the bus is idle
      else
        cnt <= count + i2c_pkg::tick_t'(1);
    end
  end

  // Period end for each phase
  always_comb begin
    case (bc.phase)
      i2c_pkg::phase_hold_start: period = thd_sta;
      i2c_pkg::phase_low:        period = tlow;
      i2c_pkg::phase_high:       period = thigh;
      default:                   period = '0;
    endcase
  end

  // SCL low until the count reaches tlow, released in the last cycle
  assign bc.scl_low = (bc.phase == i2c_pkg::phase_low) && (count < tlow);

  assign bc.change_strobe = (bc.phase == i2c_pkg::phase_low) &&
                            (count == tlow - tsu_dat);
  assign bc.sample_strobe = (bc.phase == i2c_pkg::phase_high) &&
                            (count == thigh_sample);
  assign bc.stop_strobe   = (bc.phase == i2c_pkg::phase_high) &&
                            (count == tsu_sto);
  assign bc.phase_done    = (bc.phase != i2c_pkg::phase_idle) &&
                            (count == period);  // Phase lasts period + 1 cycles

endmodule

// ==== transfer_fsm.sv ====
// Transaction sequencer: start edge detect, bit and byte counting, SDA drive
`timescale 1ns/1ps

module transfer_fsm #(
  parameter int bytes_send_log    = 2,
  parameter int bytes_receive_log = 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic [bytes_send_log-1:0]    num_bytes_send,
  input  logic [bytes_receive_log-1:0] num_bytes_receive,
  input  logic                         sda_in,
  output logic                         sda_drive_low,
  output logic                         active,
  bit_clock_if.sequencer               bc,
  frame_data_if.sequencer              fd
);

  localparam i2c_pkg::bit_idx_t last_bit = i2c_pkg::bit_idx_t'(i2c_pkg::byte_w);

  i2c_pkg::xfer_state_t state;
  i2c_pkg::bit_idx_t    bit_idx;     // Bits put on the bus in this frame
  logic                 high_half;   // Second SCL half of the current bit
  logic                 start_s1;
  logic                 start_s2;
  logic                 start_edge;  // One cycle after a rising start
  logic                 launch;
  logic                 bit_end;     // End of the high half of a bit
  logic                 ack_nack;    // Latched target acknowledge, 1 = NACK
  logic [bytes_send_log-1:0]    nsend_q;
  logic [bytes_receive_log-1:0] nrecv_q;
  logic [bytes_send_log-1:0]    send_cnt;
  logic [bytes_receive_log-1:0] recv_cnt;
  logic [bytes_send_log-1:0]    send_cnt_nx;
  logic [bytes_receive_log-1:0] recv_cnt_nx;
  logic                         last_tx;
  logic                         last_rx;

  // Two-stage capture of the start request
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      start_s1 <= 1'b0;
      start_s2 <= 1'b0;
    end else begin
      start_s1 <= start;
      start_s2 <= start_s1;
    end
  end

  assign start_edge = start_s1 & ~start_s2;
  assign launch     = (state == i2c_pkg::st_idle) && start_edge && !active;
  assign bit_end    = bc.phase_done && high_half;

  assign send_cnt_nx = send_cnt + bytes_send_log'(1);
  assign recv_cnt_nx = recv_cnt + bytes_receive_log'(1);
  assign last_tx     = (send_cnt_nx == nsend_q);  // Byte in flight is the last one
  assign last_rx     = (recv_cnt_nx == nrecv_q);

  // Phase request from state and half
  always_comb begin
    case (state)
      i2c_pkg::st_idle:      bc.phase = i2c_pkg::phase_idle;
      i2c_pkg::st_start:     bc.phase = i2c_pkg::phase_hold_start;
      i2c_pkg::st_stop_low:  bc.phase = i2c_pkg::phase_low;
      i2c_pkg::st_stop_high: bc.phase = i2c_pkg::phase_high;
      default:               bc.phase = high_half ? i2c_pkg::phase_high : i2c_pkg::phase_low;
    endcase
  end

  // Shifter controls, MSB goes out at the change strobe
  assign fd.load       = launch;
  assign fd.addr_shift = (state == i2c_pkg::st_addr) && !high_half && bc.change_strobe;
  assign fd.tx_shift   = (state == i2c_pkg::st_data) && !high_half && bc.change_strobe &&
                         !fd.read_mode;
  assign fd.rx_shift   = (state == i2c_pkg::st_data) && high_half && bc.sample_strobe &&
                         fd.read_mode;
  assign fd.rx_bit     = sda_in;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state         <= i2c_pkg::st_idle;
      high_half     <= 1'b0;
      bit_idx       <= '0;
      ack_nack      <= 1'b0;
      nsend_q       <= '0;
      nrecv_q       <= '0;
      send_cnt      <= '0;
      recv_cnt      <= '0;
      sda_drive_low <= 1'b0;
      active        <= 1'b0;
    end else begin
      if (bc.phase_done && state inside {i2c_pkg::st_addr, i2c_pkg::st_addr_ack,
                                         i2c_pkg::st_data, i2c_pkg::st_data_ack})
        high_half <= ~high_half;  // Leaves 0 when the bit ends
      case (state)
        i2c_pkg::st_idle: begin
          if (launch) begin
            state         <= i2c_pkg::st_start;
            active        <= 1'b1;
            sda_drive_low <= 1'b1;  // START, SCL still released
            high_half     <= 1'b0;
            bit_idx       <= '0;
            ack_nack      <= 1'b0;
            send_cnt      <= '0;
            recv_cnt      <= '0;
            nsend_q       <= num_bytes_send;
            nrecv_q       <= num_bytes_receive;
          end else begin
            active <= 1'b0;  // Drops one cycle after the STOP
          end
        end
        i2c_pkg::st_start: if (bc.phase_done) state <= i2c_pkg::st_addr;
        i2c_pkg::st_addr: begin
          if (!high_half && bc.change_strobe) begin
            sda_drive_low <= ~fd.addr_bit;
            bit_idx       <= bit_idx + 4'd1;
          end
          if (bit_end && bit_idx == last_bit) begin
            state   <= i2c_pkg::st_addr_ack;
            bit_idx <= '0;
          end
        end
        i2c_pkg::st_addr_ack: begin
          if (!high_half && bc.change_strobe) sda_drive_low <= 1'b0;  // Let target answer
          if (high_half && bc.sample_strobe) ack_nack <= sda_in;
          if (bit_end) state <= ack_nack ? i2c_pkg::st_stop_low : i2c_pkg::st_data;
        end
        i2c_pkg::st_data: begin
          if (!high_half && bc.change_strobe) begin
            sda_drive_low <= !fd.read_mode && !fd.tx_bit;  // Released for reads
            bit_idx       <= bit_idx + 4'd1;
          end
          if (bit_end && bit_idx == last_bit) begin
            state   <= i2c_pkg::st_data_ack;
            bit_idx <= '0;
          end
        end
        i2c_pkg::st_data_ack: begin
          if (!high_half && bc.change_strobe)
            sda_drive_low <= fd.read_mode && !last_rx;  // ACK, NACK on the last read
          if (high_half && bc.sample_strobe && !fd.read_mode) ack_nack <= sda_in;
          if (bit_end) begin
            if (fd.read_mode) begin
              recv_cnt <= recv_cnt_nx;
              state    <= last_rx ? i2c_pkg::st_stop_low : i2c_pkg::st_data;
            end else begin
              send_cnt <= send_cnt_nx;
              state    <= (ack_nack || last_tx) ? i2c_pkg::st_stop_low : i2c_pkg::st_data;
            end
          end
        end
        i2c_pkg::st_stop_low: begin
          if (bc.change_strobe) sda_drive_low <= 1'b1;  // SDA low ahead of STOP
          if (bc.phase_done) state <= i2c_pkg::st_stop_high;
        end
        i2c_pkg::st_stop_high: begin
          if (bc.stop_strobe) begin
            sda_drive_low <= 1'b0;  // SDA rises with SCL high
            state         <= i2c_pkg::st_idle;
          end
        end
        default: state <= i2c_pkg::st_idle;
      endcase
    end
  end

endmodule

// ==== frame_shifter.sv ====
// Address and transmit shift registers, receive register and R/W capture
`timescale 1ns/1ps

module frame_shifter #(
  parameter int bytes_send_log    = 2,
  parameter int bytes_receive_log = 2,
  localparam int send_w = (2**bytes_send_log - 1) * i2c_pkg::byte_w,
  localparam int recv_w = (2**bytes_receive_log - 1) * i2c_pkg::byte_w
) (
  input  logic                      clk,
  input  logic                      rst,
  input  i2c_pkg::addr_frame_t      addr_target,
  input  logic [send_w-1:0]         data_send,
  input  logic [bytes_send_log-1:0] num_bytes_send,
  output logic [recv_w-1:0]         data_received,
  frame_data_if.shifter             fd
);

  i2c_pkg::addr_frame_t        addr_sr;  // Address frame, MSB on the bus
  logic [send_w-1:0]           tx_sr;    // Right-justified write data
  logic [bytes_send_log-1:0]   nsend_q;  // Byte count sampled at load
  logic [bytes_send_log+2:0]   tx_idx;   // Top bit of the lowest nsend_q bytes
  logic                        rw_q;

  // Control and received data, cleared when a transaction starts
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      data_received <= '0;
      rw_q          <= 1'b0;
      nsend_q       <= '0;
    end else if (fd.load) begin
      data_received <= '0;
      rw_q          <= addr_target[0];
      nsend_q       <= num_bytes_send;
    end else if (fd.rx_shift) begin
      data_received <= {data_received[recv_w-2:0], fd.rx_bit};  // First byte ends up on top
    end
  end

  // Payload shift registers
  always_ff @(posedge clk) begin
    if (fd.load) begin
      addr_sr <= addr_target;
      tx_sr   <= data_send;
    end else begin
      if (fd.addr_shift) addr_sr <= addr_sr << 1;
      if (fd.tx_shift)   tx_sr   <= tx_sr << 1;
    end
  end

  assign tx_idx = {nsend_q - bytes_send_log'(1), 3'b111};  // 8 * nsend_q - 1

  assign fd.addr_bit  = addr_sr[i2c_pkg::byte_w-1];
  assign fd.tx_bit    = tx_sr[tx_idx];
  assign fd.read_mode = rw_q;

endmodule

// ==== i2c_master.sv ====
// Top level of the I2C master joining timer, sequencer and shifter to the pins
`timescale 1ns/1ps

module i2c_master #(
  parameter i2c_pkg::tick_t thd_sta      = 12,
  parameter i2c_pkg::tick_t tlow         = 16,
  parameter i2c_pkg::tick_t thigh        = 14,
  parameter i2c_pkg::tick_t tsu_dat      = 6,
  parameter i2c_pkg::tick_t tsu_sto      = 10,
  parameter i2c_pkg::tick_t thigh_sample = 5,
  parameter int bytes_send_log    = 2,  // Up to 2**log - 1 bytes per write
  parameter int bytes_receive_log = 2,  // Up to 2**log - 1 bytes per read
  localparam int send_w = (2**bytes_send_log - 1) * i2c_pkg::byte_w,
  localparam int recv_w = (2**bytes_receive_log - 1) * i2c_pkg::byte_w
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,              // Rising edge starts a transaction
  input  i2c_pkg::addr_frame_t         addr_target,
  input  logic [send_w-1:0]            data_send,
  input  logic [bytes_send_log-1:0]    num_bytes_send,     // 1 or more
  input  logic [bytes_receive_log-1:0] num_bytes_receive,  // 1 or more
  input  logic                         sda_in,             // Resolved SDA level
  output logic                         scl_drive_low,
  output logic                         sda_drive_low,
  output logic                         active,
  output logic [recv_w-1:0]            data_received
);

  bit_clock_if  bclk ();
  frame_data_if fdata ();

  scl_timer #(
    .thd_sta(thd_sta), .tlow(tlow), .thigh(thigh),
    .tsu_dat(tsu_dat), .tsu_sto(tsu_sto), .thigh_sample(thigh_sample)
  ) u_timer (
    .clk(clk),
    .rst(rst),
    .bc (bclk.timer)
  );

  transfer_fsm #(
    .bytes_send_log(bytes_send_log), .bytes_receive_log(bytes_receive_log)
  ) u_fsm (
    .clk              (clk),
    .rst              (rst),
    .start            (start),
    .num_bytes_send   (num_bytes_send),
    .num_bytes_receive(num_bytes_receive),
    .sda_in           (sda_in),
    .sda_drive_low    (sda_drive_low),
    .active           (active),
    .bc               (bclk.sequencer),
    .fd               (fdata.sequencer)
  );

  frame_shifter #(
    .bytes_send_log(bytes_send_log), .bytes_receive_log(bytes_receive_log)
  ) u_shifter (
    .clk           (clk),
    .rst           (rst),
    .addr_target   (addr_target),
    .data_send     (data_send),
    .num_bytes_send(num_bytes_send),
    .data_received (data_received),
    .fd            (fdata.shifter)
  );

  assign scl_drive_low = bclk.scl_low;  // Open-drain SCL, low while the timer says so

endmodule

// ==== i2c_master_properties.sv ====
// Concurrent assertions on the transfer sequencer, bound into transfer_fsm
`timescale 1ns/1ps

module i2c_master_properties (
  input logic                 clk,
  input logic                 rst,
  input i2c_pkg::xfer_state_t state,
  input logic                 scl_low,
  input logic                 start,
  input logic                 sda_drive_low
);

  // No SDA change while SCL is released, START and STOP excepted
  assert property (@(posedge clk) disable iff (!rst)
    (!scl_low && !(state inside {i2c_pkg::st_idle, i2c_pkg::st_stop_high}))
    |=> $stable(sda_drive_low))
    else $error("SDA drive changed with SCL high");

  // Idle is left two cycles after the raw start input rose
  assert property (@(posedge clk) disable iff (!rst)
    (state != i2c_pkg::st_idle && $past(state) == i2c_pkg::st_idle)
    |-> ($past(start, 2) && !$past(start, 3)))
    else $error("Sequencer left idle without a start edge");

  assert property (@(posedge clk) disable iff (!rst)
    state == i2c_pkg::st_idle |-> !sda_drive_low)
    else $error("SDA driven low in idle");  // Bus released between transactions

endmodule

bind transfer_fsm i2c_master_properties u_props (
  .clk(clk), .rst(rst), .state(state), .scl_low(bc.scl_low),
  .start(start), .sda_drive_low(sda_drive_low)
);

// ==== tb_i2c_master.sv ====
// Testbench for the I2C master: clock, reset, bus target model, case reader, checks, watchdog
`timescale 1ns/1ps

module tb_i2c_master;

  localparam int recv_w = 24;  // Three bytes at the default log of 2
  localparam int send_w = 24;
  localparam int bit_time = 16 + 14 + 2;  // tlow + thigh + 2 clocks per SCL bit
  localparam int case_limit = 4 + 2 * (9 * 4) * bit_time;

  logic clk = 1'b0;
  logic rst, start, sda_in;
  i2c_pkg::addr_frame_t addr_target;
  logic [send_w-1:0] data_send;
  logic [1:0] num_bytes_send, num_bytes_receive;
  logic scl_drive_low, sda_drive_low, active;
  logic [recv_w-1:0] data_received;
  logic tgt_low;  // Target pulls SDA low
  logic scl, sda;

  // Case table
  logic [8*16-1:0] c_name [16];
  logic [7:0] c_addr [16], c_tgt [16];
  logic [send_w-1:0] c_data [16], c_rd [16], c_exp_wr [16];
  logic [recv_w-1:0] c_exp_rd [16];
  int c_nsend [16], c_nrecv [16], c_nack [16];
  int n_cases, errors, failed, cycles, limit;
  logic test_bad;

  // Target model state
  logic [6:0] cur_tgt;
  logic [send_w-1:0] cur_rd;
  int cur_nack;
  logic prev_scl, prev_sda;
  int pos, mode, wr_cnt, rd_idx, n_start, n_stop;  // mode 0 none, 1 addr, 2 write, 3 read
  int scl_rises;  // SCL clocks since the last START
  i2c_pkg::byte_t sh, rd_sr, addr_byte, ack_log;
  i2c_pkg::byte_t wr_bytes [4];
  logic tgt_ack;

  assign scl = ~scl_drive_low;
  assign sda = ~(sda_drive_low | tgt_low);  // Wired-AND bus
  assign sda_in = sda;

  i2c_master u_dut (
    .clk(clk), .rst(rst), .start(start), .addr_target(addr_target),
    .data_send(data_send), .num_bytes_send(num_bytes_send),
    .num_bytes_receive(num_bytes_receive), .sda_in(sda_in),
    .scl_drive_low(scl_drive_low), .sda_drive_low(sda_drive_low),
    .active(active), .data_received(data_received)
  );

  always #50 clk = ~clk;

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Bus target, follows SCL and SDA edges seen at each clock
  always @(posedge clk) begin
    if (prev_scl && scl && prev_sda && !sda) begin  // START
      n_start = n_start + 1;
      mode = 1;
      pos = 0;
      wr_cnt = 0;
      rd_idx = 0;
      scl_rises = 0;
      ack_log = '0;
      sh = '0;
    end else if (prev_scl && scl && !prev_sda && sda) begin  // STOP
      n_stop = n_stop + 1;
      mode = 0;
      tgt_low <= 1'b0;
    end else if (!prev_scl && scl) begin  // Rising SCL, sample
      scl_rises = scl_rises + 1;
      if (pos < 8 && (mode == 1 || mode == 2)) sh = {sh[6:0], sda};
      if (pos == 8) begin
        if (mode == 1) mode = tgt_ack ? (addr_byte[0] ? 3 : 2) : 0;
        else if (mode == 2) mode = tgt_ack ? 2 : 0;
        else if (mode == 3) begin
          ack_log[rd_idx] = sda;  // 1 marks a NACK from the master
          rd_idx = rd_idx + 1;
          if (sda) mode = 0;
        end
      end
      pos = (pos == 8) ? 0 : pos + 1;
    end else if (prev_scl && !scl) begin  // Falling SCL, change drive
      if (pos == 8) begin
        if (mode == 1) begin
          addr_byte = sh;
          tgt_ack = (sh[7:1] == cur_tgt);
          tgt_low <= tgt_ack;
        end else if (mode == 2) begin
          if (wr_cnt < 4) wr_bytes[wr_cnt] = sh;
          wr_cnt = wr_cnt + 1;
          tgt_ack = (cur_nack == 0) || (wr_cnt != cur_nack);
          tgt_low <= tgt_ack;
        end else tgt_low <= 1'b0;  // Master answers a read byte
      end else if (mode == 3) begin
        if (pos == 0) rd_sr = cur_rd[8*(2-rd_idx) +: 8];  // First byte on top
        tgt_low <= ~rd_sr[7-pos];
      end else tgt_low <= 1'b0;
    end
    prev_scl <= scl;
    prev_sda <= sda;
  end

  task automatic check_byte(input logic [8*16-1:0] name, input string what,
                            input i2c_pkg::byte_t exp, input i2c_pkg::byte_t act);
    if (exp !== act) begin
      $display("error %0s %s expected %h actual %h", name, what, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_data(input logic [8*16-1:0] name,
                            input logic [recv_w-1:0] exp, input logic [recv_w-1:0] act);
    if (exp !== act) begin
      $display("error %0s data_received expected %h actual %h", name, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic complain(input string msg);
    $display("%s", msg);
    errors++;
    test_bad = 1'b1;
  endtask

  task automatic read_cases();
    int fd, n;
    string line;
    fd = $fopen("i2c_cases.txt", "r");
    if (fd == 0) complain("case file i2c_cases.txt could not be opened");
    n_cases = 0;
    while (fd != 0 && !$feof(fd) && n_cases < 16) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %d %d %h %h %h %d %h %h", c_name[n_cases], c_addr[n_cases],
                    c_nsend[n_cases], c_nrecv[n_cases], c_data[n_cases], c_tgt[n_cases],
                    c_rd[n_cases], c_nack[n_cases], c_exp_wr[n_cases], c_exp_rd[n_cases]);
        if (n == 10) n_cases++;
        else complain("a line of i2c_cases.txt could not be parsed");
      end
    end
    if (fd != 0) $fclose(fd);
    if (n_cases == 0) complain("no test cases read from i2c_cases.txt");
  endtask

  task automatic run_case(input int k);
    int starts0, stops0, wait_n, exp_cnt, exp_rises;
    logic match;
    i2c_pkg::byte_t exp_ack;
    test_bad = 1'b0;
    cur_tgt = c_tgt[k][6:0];
    cur_rd = c_rd[k];
    cur_nack = c_nack[k];
    starts0 = n_start;
    stops0 = n_stop;
    @(posedge clk);
    addr_target <= c_addr[k];
    data_send <= c_data[k];
    num_bytes_send <= 2'(c_nsend[k]);
    num_bytes_receive <= 2'(c_nrecv[k]);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_n = 0;
    while (!active && wait_n < 4) begin
      @(posedge clk);
      wait_n++;
    end
    if (!active || !sda_drive_low || scl_drive_low)
      complain("no START: SDA low and active missing 4 cycles after the start edge");
    repeat (40) @(posedge clk);
    if (n_start != starts0 + 1) complain("no START condition seen on the bus");
    start <= 1'b1;  // Pulse inside the transaction, must be ignored
    @(posedge clk);
    start <= 1'b0;
    wait_n = 0;
    while (active && wait_n < case_limit) begin
      @(posedge clk);
      wait_n++;
    end
    if (active) complain("active never fell at the end of the transaction");
    if (n_stop != stops0 + 1) complain("no STOP condition seen on the bus");
    repeat (20) @(posedge clk);
    if (active || n_start > starts0 + 1)
      complain("start pulse during the transaction began another transaction");
    // Expected bus traffic from the case columns
    match = (c_addr[k][7:1] == c_tgt[k][6:0]);
    if (!match || c_addr[k][0]) exp_cnt = 0;
    else if (c_nack[k] != 0 && c_nack[k] < c_nsend[k]) exp_cnt = c_nack[k];
    else exp_cnt = c_nsend[k];
    if (match && c_addr[k][0]) exp_rises = 9 * (1 + c_nrecv[k]) + 1;
    else exp_rises = 9 * (1 + exp_cnt) + 1;  // Address, data bytes, then STOP
    exp_ack = (match && c_addr[k][0]) ? i2c_pkg::byte_t'(1 << (c_nrecv[k] - 1)) : '0;
    check_byte(c_name[k], "address", c_addr[k], addr_byte);
    check_byte(c_name[k], "write count", i2c_pkg::byte_t'(exp_cnt), i2c_pkg::byte_t'(wr_cnt));
    check_byte(c_name[k], "scl clocks", i2c_pkg::byte_t'(exp_rises),
               i2c_pkg::byte_t'(scl_rises));
    for (int i = 0; i < exp_cnt && i < 4; i++)
      check_byte(c_name[k], "write byte", c_exp_wr[k][8*(exp_cnt-1-i) +: 8], wr_bytes[i]);
    check_byte(c_name[k], "master ack", exp_ack, ack_log);
    check_data(c_name[k], c_exp_rd[k], data_received);
    if (test_bad) failed++;
    $display("test %0s %s", c_name[k], test_bad ? "failed" : "ok");
  endtask

  initial begin
    rst = 1'b0;
    start = 1'b0;
    addr_target = '0;
    data_send = '0;
    num_bytes_send = 2'd1;
    num_bytes_receive = 2'd1;
    tgt_low = 1'b0;
    prev_scl = 1'b1;
    prev_sda = 1'b1;
    pos = 0;
    mode = 0;
    wr_cnt = 0;
    rd_idx = 0;
    scl_rises = 0;
    n_start = 0;
    n_stop = 0;
    ack_log = '0;
    addr_byte = '0;
    tgt_ack = 1'b0;
    errors = 0;
    failed = 0;
    cycles = 0;
    limit = 1000000;
    read_cases();
    limit = n_cases * (case_limit + 80) + 400;
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    test_bad = 1'b0;
    repeat (20) @(posedge clk);  // Idle after reset
    if (scl_drive_low || sda_drive_low || active)
      complain("bus drive or active high after reset without a start");
    check_data("reset", '0, data_received);
    if (test_bad) failed++;
    $display("test reset %s", test_bad ? "failed" : "ok");
    for (int k = 0; k < n_cases; k++) run_case(k);
    $display("tests %0d, failed %0d, errors %0d", n_cases + 1, failed, errors);
    if (errors == 0 && n_cases > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== i2c_cases.txt ====
# name addr_target nsend nrecv data_send tgt_addr read_bytes nack_byte exp_write exp_read
# hex except counts and nack_byte; nack_byte 0 means the target ACKs every written byte
wr1 a4 1 1 112233 52 000000 0 000033 000000
wr2 a4 2 1 a1b2c3 52 000000 0 00b2c3 000000
wr3 a4 3 1 5a0ff0 52 000000 0 5a0ff0 000000
rd1 a5 1 1 000000 52 3c0000 0 000000 00003c
rd3 a5 1 3 000000 52 c3d4e5 0 000000 c3d4e5
nomatch 6d 1 2 000000 52 abcdef 0 000000 000000
nack1 a4 3 1 778899 52 000000 1 000077 000000

// ==== compile.f ====
i2c_pkg.sv
bit_clock_if.sv
frame_data_if.sv
scl_timer.sv
transfer_fsm.sv
frame_shifter.sv
i2c_master.sv
i2c_master_properties.sv
tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the I2C master testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_i2c_master -o sim_i2c
./obj_dir/sim_i2c > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1
